//--- list.f
+incdir+tb
src/heapParamsPkg.sv
src/heapOpsPkg.sv
src/arrayAllocator.sv
src/requestStage.sv
src/elementStage.sv
src/heapTop.sv
tb/heapTb.sv

//--- Makefile
# Verilator build, run, lint and clean for the heap testbench

VERILATOR ?= verilator
TOP       ?= heapTb
FILELIST  ?= list.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal
PASS_TEXT ?= Verification passed

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

run: build
	-./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -q "$(PASS_TEXT)" $(LOG)

lint:
	$(VERILATOR) --lint-only --timing --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- tb/heapTasks.svh
// ------------------------------------------------
// Testbench tasks: request driving, done polling,
// value compare and a reference model of the heap
// ------------------------------------------------
`ifndef HEAP_TASKS_SVH
`define HEAP_TASKS_SVH

// ------------------------------------------------
// Reference model state
// ------------------------------------------------
logic [dataBits-1:0] modelStore [numArrays][arrayLength]; // Element contents
int                  modelSize  [numArrays];              // Current sizes
bit                  modelAlloc [numArrays];              // Usable arrays
int                  modelFresh;                          // Numbers ever handed out
int                  freeList [$];                        // Back is stack top

task automatic compareValue(input string name, input logic [31:0] got,
                            input logic [31:0] exp);
  if (got !== exp) begin
    $display("ERR t=%0t %s got=0x%0h expected=0x%0h", $time, name, got, exp);
    $display("Verification failed");
    $fatal(1, "Stopped at first mismatch");
  end
endtask

// Expected out and error per the heap rules, model updated in request order
task automatic modelStep(input heapOp op, input int arr, input int idx,
                         input logic [dataBits-1:0] data,
                         output logic [dataBits-1:0] expOut, output heapError expErr);
  logic [dataBits-1:0] old;
  int                  grant;
  expOut = '0;
  expErr = errNone;
  grant  = -1;
  if (op == opAlloc) begin
    if (freeList.size() > 0) begin
      grant = freeList.pop_back();                   // Newest freed first
    end else if (modelFresh < numArrays) begin
      grant = modelFresh;
      modelFresh++;
    end else begin
      expErr = errOutOfMemory;
    end
    if (grant >= 0) begin
      modelAlloc[grant] = 1'b1;
      modelSize[grant]  = 0;                         // New array is empty
      expOut            = dataBits'(grant);
    end
  end else if (arr >= modelFresh) begin
    expErr = errNotAllocated;
  end else if (!modelAlloc[arr]) begin
    expErr = errFreed;                               // Also the double free
  end else begin
    case (op)
      opWrite: begin
        modelStore[arr][idx] = data;
        if (idx >= modelSize[arr]) modelSize[arr] = idx + 1;
        expOut = data;
      end
      opSize: expOut = dataBits'(modelSize[arr]);
      opPush: begin
        if (modelSize[arr] == arrayLength) begin
          expErr = errFull;
        end else begin
          modelStore[arr][modelSize[arr]] = data;   // Append at end
          modelSize[arr]++;
          expOut = data;
        end
      end
      opPop: begin
        if (modelSize[arr] == 0) begin
          expErr = errEmpty;
        end else begin
          modelSize[arr]--;
          expOut = modelStore[arr][modelSize[arr]];
        end
      end
      opFree: begin
        modelAlloc[arr] = 1'b0;
        freeList.push_back(arr);
      end
      default: begin                                 // Read and in-place ops
        if (idx >= modelSize[arr]) begin
          expErr = errOutOfBounds;
        end else begin
          old = modelStore[arr][idx];
          case (op)
            opAdd:   expOut = old + data;            // Wraps at 16 bits
            opXor:   expOut = old ^ data;
            opAnd:   expOut = old & data;
            opOr:    expOut = old | data;
            default: expOut = old;                   // Read, add-after
          endcase
          if (op == opAddAfter) modelStore[arr][idx] = old + data;
          else if (op != opRead) modelStore[arr][idx] = expOut;
        end
      end
    endcase
  end
endtask

task automatic driveRequest(input heapOp op, input int arr, input int idx,
                            input logic [dataBits-1:0] data);
  request = 1'b1;
  action  = op;
  array   = arrayBits'(arr);
  index   = indexBits'(idx);
  in      = data;
endtask

task automatic waitDone(input int limit);
  int cycles;
  cycles = 0;
  while (done !== 1'b1) begin
    @(negedge clock);
    cycles++;
    if (cycles > limit) begin
      $display("Timeout: done never arrived within %0d cycles", limit);
      $display("Verification failed");
      $fatal(1, "Run stopped on timeout");
    end
  end
endtask

// One request, then check against the model
task automatic runOp(input heapOp op, input int arr, input int idx,
                     input logic [dataBits-1:0] data);
  logic [dataBits-1:0] expOut;
  heapError            expErr;
  modelStep(op, arr, idx, data, expOut, expErr);
  driveRequest(op, arr, idx, data);
  @(negedge clock);
  request = 1'b0;                                    // Single-cycle strobe
  waitDone(10);
  compareValue("out", out, expOut);
  compareValue("error", error, expErr);
endtask

`endif

//--- tb/heapTb.sv
// ------------------------------------------------
// Testbench top: clock, reset, heap DUT and the
// directed tests
// ------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module heapTb
  import heapParamsPkg::*, heapOpsPkg::*;
();

  logic                 clock = 1'b0;
  logic                 reset;
  logic                 request;
  heapOp                action;
  logic [arrayBits-1:0] array;
  logic [indexBits-1:0] index;
  logic [dataBits-1:0]  in;
  logic                 done;
  logic [dataBits-1:0]  out;
  heapError             error;
  int                   seed = 91665;                // Fixed random seed

  always #10 clock = ~clock;                         // 20 ns period

  heapTop i_heapTop (
    .clock   (clock),
    .reset   (reset),
    .request (request),
    .action  (action),
    .array   (array),
    .index   (index),
    .in      (in),
    .done    (done),
    .out     (out),
    .error   (error)
  );

  `include "heapTasks.svh"

  // ------------------------------------------------
  // Directed tests
  // ------------------------------------------------
  task automatic allocTest();
    runOp(opRead, 7, 0, '0);                         // Never handed out
    runOp(opFree, 7, 0, '0);
    repeat (3) runOp(opAlloc, 0, 0, '0);             // 0, 1, 2
    runOp(opFree, 1, 0, '0);
    runOp(opFree, 0, 0, '0);
    repeat (2) runOp(opAlloc, 0, 0, '0);             // LIFO gives 0 then 1
    repeat (6) runOp(opAlloc, 0, 0, '0);             // 3 to 7, then out of memory
  endtask

  task automatic readWriteTest();
    runOp(opWrite, 2, 5, dataBits'($random(seed)));
    runOp(opSize, 2, 0, '0);                         // Size grows to 6
    runOp(opWrite, 2, 2, dataBits'($random(seed)));
    runOp(opRead, 2, 5, '0);
    runOp(opRead, 2, 2, '0);
    runOp(opRead, 2, 6, '0);                         // Out of bounds
  endtask

  task automatic pushPopTest();
    repeat (arrayLength + 1) runOp(opPush, 3, 0, dataBits'($random(seed))); // Last one full
    repeat (arrayLength + 1) runOp(opPop, 3, 0, '0); // Last one empty
  endtask

  task automatic arithTest();
    heapOp arithOps [5];
    int    pick;
    arithOps = '{opAdd, opAddAfter, opXor, opAnd, opOr};
    for (int i = 0; i < 4; i++) begin
      runOp(opWrite, 4, i, dataBits'($random(seed)));
    end
    runOp(opWrite, 4, 0, 16'hfff0);
    runOp(opAdd, 4, 0, 16'h0020);                    // Sum wraps
    runOp(opAddAfter, 4, 0, 16'hffff);               // Old value back
    repeat (20) begin
      pick = {$random(seed)} % 20;
      runOp(arithOps[pick % 5], 4, pick % 4, dataBits'($random(seed)));
    end
  endtask

  task automatic freeTest();
    runOp(opFree, 5, 0, '0);
    runOp(opRead, 5, 0, '0);                         // Freed array
    runOp(opFree, 5, 0, '0);                         // Double free rejected
    runOp(opAlloc, 0, 0, '0);                        // Stack still holds only 5
    runOp(opAlloc, 0, 0, '0);
  endtask

  // Requests on consecutive cycles, done exactly two cycles later
  task automatic pipelineTest();
    heapOp               ops    [4];
    logic [dataBits-1:0] vals   [4];
    logic [dataBits-1:0] expOut [4];
    heapError            expErr [4];
    ops = '{opWrite, opRead, opPush, opSize};
    for (int c = 0; c < 4; c++) begin
      vals[c] = dataBits'($random(seed));
    end
    for (int c = 0; c < 7; c++) begin
      if (c < 4) begin
        modelStep(ops[c], 6, 1, vals[c], expOut[c], expErr[c]);
        driveRequest(ops[c], 6, 1, vals[c]);
      end else begin
        request = 1'b0;
      end
      if (c >= 2 && c < 6) begin
        compareValue("done", done, 1'b1);
        compareValue("out", out, expOut[c-2]);
        compareValue("error", error, expErr[c-2]);
      end else if (c == 6) begin
        compareValue("done", done, 1'b0);            // No extra strobe
      end
      @(negedge clock);
    end
  endtask

  initial begin
    reset   = 1'b1;
    request = 1'b0;
    action  = opRead;
    array   = '0;
    index   = '0;
    in      = '0;
    repeat (8) @(negedge clock);                     // Reset for 8 cycles
    reset = 1'b0;
    @(negedge clock);
    allocTest();
    readWriteTest();
    pushPopTest();
    arithTest();
    freeTest();
    pipelineTest();
    $display("Verification passed");
    $finish;
  end

endmodule

`default_nettype wire

//--- src/heapTop.sv
// ------------------------------------------------
// Heap top level: request stage feeding
// element stage, two-cycle fixed latency
// ------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module heapTop
  import heapParamsPkg::*, heapOpsPkg::*;
(
  input  wire logic                 clock,
  input  wire logic                 reset,
  input  wire logic                 request,         // One-cycle strobe
  input  wire heapOp                action,
  input  wire logic [arrayBits-1:0] array,
  input  wire logic [indexBits-1:0] index,
  input  wire logic [dataBits-1:0]  in,
  output logic                      done,            // Two cycles after request
  output logic      [dataBits-1:0]  out,
  output heapError                  error
);

  // ------------------------------------------------
  // Stage link
  // ------------------------------------------------
  logic                 stageValid;
  heapOp                stageOp;
  logic [arrayBits-1:0] stageSlotArray;
  logic [indexBits-1:0] stageSlotIndex;
  logic [dataBits-1:0]  stageIn;
  logic [dataBits-1:0]  stageResult;
  heapError             stageError;

  requestStage i_requestStage (
    .clock          (clock),
    .reset          (reset),
    .request        (request),
    .action         (action),
    .array          (array),
    .index          (index),
    .in             (in),
    .stageValid     (stageValid),
    .stageOp        (stageOp),
    .stageSlotArray (stageSlotArray),
    .stageSlotIndex (stageSlotIndex),
    .stageIn        (stageIn),
    .stageResult    (stageResult),
    .stageError     (stageError)
  );

  elementStage i_elementStage (
    .clock          (clock),
    .reset          (reset),
    .stageValid     (stageValid),
    .stageOp        (stageOp),
    .stageSlotArray (stageSlotArray),
    .stageSlotIndex (stageSlotIndex),
    .stageIn        (stageIn),
    .stageResult    (stageResult),
    .stageError     (stageError),
    .done           (done),
    .out            (out),
    .error          (error)
  );

endmodule

`default_nettype wire

//--- src/elementStage.sv
// ------------------------------------------------
// Element stage: element store and in-place
// arithmetic, registers done, out and error
// ------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module elementStage
  import heapParamsPkg::*, heapOpsPkg::*;
(
  input  wire logic                 clock,
  input  wire logic                 reset,
  input  wire logic                 stageValid,
  input  wire heapOp                stageOp,
  input  wire logic [arrayBits-1:0] stageSlotArray,
  input  wire logic [indexBits-1:0] stageSlotIndex,
  input  wire logic [dataBits-1:0]  stageIn,
  input  wire logic [dataBits-1:0]  stageResult,
  input  wire heapError             stageError,
  output logic                      done,            // One-cycle strobe
  output logic      [dataBits-1:0]  out,
  output heapError                  error
);

  logic [dataBits-1:0] store [numArrays][arrayLength]; // All arrays, fixed blocks
  logic [dataBits-1:0] oldValue;                     // Element before update
  logic [dataBits-1:0] newValue;
  logic [dataBits-1:0] result;
  logic                writeEn;

  assign oldValue = store[stageSlotArray][stageSlotIndex];

  // ------------------------------------------------
  // Element operation
  // ------------------------------------------------
  always_comb begin
    newValue = stageIn;
    writeEn  = 1'b0;
    result   = '0;
    case (stageOp)
      opWrite, opPush: begin
        writeEn = 1'b1;
        result  = stageIn;                           // Echo stored value
      end
      opRead, opPop: result = oldValue;
      opAdd, opAddAfter: begin
        newValue = oldValue + stageIn;               // Wraps at dataBits
        writeEn  = 1'b1;
        result   = (stageOp == opAdd) ? newValue : oldValue;
      end
      opXor: begin
        newValue = oldValue ^ stageIn;
        writeEn  = 1'b1;
        result   = newValue;
      end
      opAnd: begin
        newValue = oldValue & stageIn;
        writeEn  = 1'b1;
        result   = newValue;
      end
      opOr: begin
        newValue = oldValue | stageIn;
        writeEn  = 1'b1;
        result   = newValue;
      end
      opSize, opAlloc: result = stageResult;         // Known in first stage
      default: ;                                     // Free returns zero
    endcase
    if (stageError != errNone) begin
      writeEn = 1'b0;                                // Failed request leaves store
      result  = '0;
    end
  end

  always_ff @(posedge clock) begin
    if (stageValid && writeEn) store[stageSlotArray][stageSlotIndex] <= newValue;
  end

  always_ff @(posedge clock) begin
    done  <= reset ? 1'b0 : stageValid;
    out   <= result;
    error <= stageError;
  end

  // Clean element access completes without error next cycle
  assert property (@(posedge clock) disable iff (reset)
    (stageValid && stageError == errNone &&
     stageOp inside {opRead, opWrite, opAdd, opAddAfter, opXor, opAnd, opOr})
    |=> (done && error == errNone));

endmodule

`default_nettype wire

//--- src/requestStage.sv
// ------------------------------------------------
// Request stage: checks each request, keeps the
// size table and resolves the element slot
// ------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module requestStage
  import heapParamsPkg::*, heapOpsPkg::*;
(
  input  wire logic                 clock,
  input  wire logic                 reset,
  input  wire logic                 request,         // One-cycle strobe
  input  wire heapOp                action,
  input  wire logic [arrayBits-1:0] array,
  input  wire logic [indexBits-1:0] index,
  input  wire logic [dataBits-1:0]  in,
  output logic                      stageValid,
  output heapOp                     stageOp,
  output logic      [arrayBits-1:0] stageSlotArray,
  output logic      [indexBits-1:0] stageSlotIndex,
  output logic      [dataBits-1:0]  stageIn,
  output logic      [dataBits-1:0]  stageResult,     // Size or granted number
  output heapError                  stageError
);

  logic [sizeBits-1:0]  sizes [numArrays];           // Current size per array
  logic [sizeBits-1:0]  curSize;                     // Size of addressed array
  logic [sizeBits-1:0]  popSize;                     // Size after a pop
  logic [indexBits-1:0] slotIndex;
  logic [dataBits-1:0]  result;
  heapError             checkError;
  heapError             queryStatus;
  heapError             grantStatus;
  logic [arrayBits-1:0] granted;
  logic                 allocate;
  logic                 releaseReq;

  assign curSize    = sizes[array];
  assign popSize    = curSize - 1'b1;
  assign allocate   = request && action == opAlloc;
  assign releaseReq = request && action == opFree && checkError == errNone; // Checked frees only

  arrayAllocator i_arrayAllocator (
    .clock        (clock),
    .reset        (reset),
    .allocate     (allocate),
    .releaseReq   (releaseReq),
    .releaseArray (array),
    .queryArray   (array),
    .queryStatus  (queryStatus),
    .granted      (granted),
    .grantStatus  (grantStatus)
  );

  // ------------------------------------------------
  // Checks and slot resolution
  // ------------------------------------------------
  always_comb begin
    checkError = queryStatus;                        // Allocation check first
    slotIndex  = index;
    result     = '0;
    case (action)
      opAlloc: begin
        checkError = grantStatus;                    // Array need not exist yet
        result     = dataBits'(granted);
      end
      opSize: result = dataBits'(curSize);
      opRead, opAdd, opAddAfter, opXor, opAnd, opOr: begin
        if (checkError == errNone && {1'b0, index} >= curSize) checkError = errOutOfBounds;
      end
      opPush: begin
        slotIndex = curSize[indexBits-1:0];          // Append slot
        if (checkError == errNone && curSize == sizeBits'(arrayLength)) checkError = errFull;
      end
      opPop: begin
        slotIndex = popSize[indexBits-1:0];          // Last element
        if (checkError == errNone && curSize == '0) checkError = errEmpty;
      end
      default: ;                                     // Write and free need no more
    endcase
  end

  // ------------------------------------------------
  // Size table
  // ------------------------------------------------
  always_ff @(posedge clock) begin
    if (reset) begin
      for (int a = 0; a < numArrays; a++) begin
        sizes[a] <= '0;
      end
    end else if (request && checkError == errNone) begin
      case (action)
        opWrite: if ({1'b0, index} >= curSize) sizes[array] <= {1'b0, index} + 1'b1;
        opPush:  sizes[array]   <= curSize + 1'b1;
        opPop:   sizes[array]   <= popSize;
        opAlloc: sizes[granted] <= '0;               // New array starts empty
        default: ;
      endcase
    end
  end

  // Pipeline register into element stage
  always_ff @(posedge clock) begin
    stageValid     <= reset ? 1'b0 : request;
    stageOp        <= action;
    stageSlotArray <= array;
    stageSlotIndex <= slotIndex;
    stageIn        <= in;
    stageResult    <= result;
    stageError     <= checkError;
  end

  assert property (@(posedge clock) reset |=> !stageValid);

  for (genvar a = 0; a < numArrays; a++) begin : gSizeCheck
    assert property (@(posedge clock) disable iff (reset) sizes[a] <= sizeBits'(arrayLength));
  end

endmodule

`default_nettype wire

//--- src/arrayAllocator.sv
// ------------------------------------------------
// Array allocator: allocation flags, fresh counter
// and LIFO stack of freed array numbers
// ------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module arrayAllocator
  import heapParamsPkg::*, heapOpsPkg::*;
(
  input  wire logic                 clock,
  input  wire logic                 reset,
  input  wire logic                 allocate,      // Take the granted array
  input  wire logic                 releaseReq,    // Push releaseArray on stack
  input  wire logic [arrayBits-1:0] releaseArray,
  input  wire logic [arrayBits-1:0] queryArray,    // Array being checked
  output heapError                  queryStatus,
  output logic      [arrayBits-1:0] granted,       // Next array to hand out
  output heapError                  grantStatus
);

  logic [numArrays-1:0] allocated;                   // One flag per array
  logic [arrayBits:0]   freshCount;                  // Arrays ever handed out
  logic [arrayBits:0]   stackDepth;                  // Entries on free stack
  logic [arrayBits:0]   topPtr;                      // Depth minus one
  logic [arrayBits-1:0] freeStack [numArrays];       // Freed numbers, newest on top

  assign topPtr = stackDepth - 1'b1;

  // ------------------------------------------------
  // Status of the queried array
  // ------------------------------------------------
  always_comb begin
    if ({1'b0, queryArray} >= freshCount) queryStatus = errNotAllocated;
    else if (!allocated[queryArray])      queryStatus = errFreed;  // Includes double free
    else                                  queryStatus = errNone;
  end

  // Reuse beats fresh numbers
  always_comb begin
    if (stackDepth != '0) begin
      granted     = freeStack[topPtr[arrayBits-1:0]]; // Most recently freed
      grantStatus = errNone;
    end else if (freshCount < numArrays) begin
      granted     = freshCount[arrayBits-1:0];
      grantStatus = errNone;
    end else begin
      granted     = '0;
      grantStatus = errOutOfMemory;                  // Every array is out
    end
  end

  // ------------------------------------------------
  // Bookkeeping updates
  // ------------------------------------------------
  always_ff @(posedge clock) begin
    if (reset) begin
      allocated  <= '0;
      freshCount <= '0;
      stackDepth <= '0;
    end else begin
      if (allocate && grantStatus == errNone) begin
        allocated[granted] <= 1'b1;
        if (stackDepth != '0) stackDepth <= topPtr;  // Pop
        else                  freshCount <= freshCount + 1'b1;
      end
      if (releaseReq) begin
        freeStack[stackDepth[arrayBits-1:0]] <= releaseArray;
        stackDepth                           <= stackDepth + 1'b1;
        allocated[releaseArray]              <= 1'b0;
      end
    end
  end

  // Stack bounded by array count
  assert property (@(posedge clock) disable iff (reset) stackDepth <= numArrays);
  // One request per cycle
  assert property (@(posedge clock) disable iff (reset) !(allocate && releaseReq));

endmodule

`default_nettype wire

//--- src/heapOpsPkg.sv
// ------------------------------------------------
// Heap request opcodes and error codes
// ------------------------------------------------
`default_nettype none

package heapOpsPkg;

  // Operations a client can request
  typedef enum logic [4:0] {
    opWrite,                                         // Store in, grow size
    opRead,                                          // Fetch element
    opSize,                                          // Current size
    opPush,                                          // Append at end
    opPop,                                           // Remove from end
    opAlloc,                                         // Get an array number
    opFree,                                          // Return array for reuse
    opAdd,                                           // Add, return new value
    opAddAfter,                                      // Add, return old value
    opXor,                                           // Bitwise xor in place
    opAnd,                                           // Bitwise and in place
    opOr                                             // Bitwise or in place
  } heapOp;

  // Outcome of a request
  typedef enum logic [2:0] {
    errNone,                                         // Request carried out
    errNotAllocated,                                 // Never handed out
    errFreed,                                        // Handed out, now free
    errOutOfBounds,                                  // Index at or past size
    errFull,                                         // Push onto full array
    errEmpty,                                        // Pop from empty array
    errOutOfMemory                                   // No array left to grant
  } heapError;

endpackage

`default_nettype wire

//--- src/heapParamsPkg.sv
// ------------------------------------------------
// Heap geometry: array count, array length and
// element width, with the widths derived from them
// ------------------------------------------------
`default_nettype none

package heapParamsPkg;

  // ------------------------------------------------
  // Array numbering
  // ------------------------------------------------
  localparam int arrayBits   = 3;                    // Bits in an array number
  localparam int numArrays   = 1 << arrayBits;       // Arrays in the heap

  // ------------------------------------------------
  // Element indexing and payload
  // ------------------------------------------------
  localparam int indexBits   = 3;                    // Bits in an element index
  localparam int arrayLength = 1 << indexBits;       // Elements per array
  localparam int sizeBits    = indexBits + 1;        // Size must reach arrayLength
  localparam int dataBits    = 16;                   // Element width

endpackage

`default_nettype wire
